//--- hdl/crc_pkg.sv
package crc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// CRC-32 constants

	// Width of the running CRC state
	localparam int crc_width = 32;

	// Ethernet polynomial 0x04C11DB7, bit reversed for LSB-first shifting
	localparam logic [crc_width-1:0] crc_poly = 32'hEDB88320;

	// Every frame starts from all ones
	localparam logic [crc_width-1:0] crc_init = 32'hFFFFFFFF;

	// Bytes folded by one full pipeline block
	localparam int block_bytes = 16;

	// Final block byte count, 1 to 16
	localparam int len_width = 5;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline input and output

	// One block towards the pipeline
	// Byte 0 sits in data[127:120]
	typedef struct packed {
		logic                     update;
		logic                     start;
		logic                     last;
		logic [len_width-1:0]     len;
		logic [block_bytes*8-1:0] data;
	} crc_block_t;

	// Finished frame, valid is a single cycle pulse
	typedef struct packed {
		logic                 valid;
		logic [crc_width-1:0] crc;
	} crc_result_t;

	// Advance the state by one byte, LSB of the byte first
	function automatic logic [crc_width-1:0] crc32_byte_step(
		input logic [crc_width-1:0] c,
		input logic [7:0]           b
	);
		logic [crc_width-1:0] s;
		s = c ^ {{(crc_width-8){1'b0}}, b};
		for (int i = 0; i < 8; i++) begin
			s = s[0] ? ((s >> 1) ^ crc_poly) : (s >> 1);
		end
		return s;
	endfunction

endpackage

//--- hdl/wb_pkg.sv
package wb_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone bus widths

	localparam int wb_adr_width = 3;
	localparam int wb_dat_width = 32;

	// Word addresses of the register map
	// Lane 0 holds bytes 0 to 3, byte 0 in bits 31:24
	localparam logic [wb_adr_width-1:0] reg_lane0  = 3'd0;
	localparam logic [wb_adr_width-1:0] reg_lane1  = 3'd1;
	localparam logic [wb_adr_width-1:0] reg_lane2  = 3'd2;
	localparam logic [wb_adr_width-1:0] reg_lane3  = 3'd3;
	localparam logic [wb_adr_width-1:0] reg_cmd    = 3'd4;
	localparam logic [wb_adr_width-1:0] reg_result = 3'd5;
	// Done in bit 0, busy in bit 1
	localparam logic [wb_adr_width-1:0] reg_status = 3'd6;

	// Master to slave
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [wb_adr_width-1:0] adr;
		logic [wb_dat_width-1:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic                    ack;
		logic [wb_dat_width-1:0] dat;
	} wb_rsp_t;

	// Command word layout
	typedef struct packed {
		logic [wb_dat_width-crc_pkg::len_width-3:0] reserved;
		logic                                       start;
		logic                                       last;
		logic [crc_pkg::len_width-1:0]              len;
	} crc_cmd_t;

	// Write word seen as a plain lane or as a command
	typedef union packed {
		logic [wb_dat_width-1:0] raw;
		crc_cmd_t                cmd;
	} wb_word_u;

endpackage

//--- hdl/crc32_block_comb.sv
module crc32_block_comb #(
	parameter int BYTES = 16
) (
	input  logic [BYTES*8-1:0]            d,
	input  logic [crc_pkg::crc_width-1:0] c,
	output logic [crc_pkg::crc_width-1:0] crc
);
	import crc_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Fold BYTES whole bytes into the state

	// First byte on the wire is the most significant byte of d
	// The loop unrolls into one XOR tree per state bit
	always_comb begin
		crc = c;
		for (int i = 0; i < BYTES; i++) begin
			crc = crc32_byte_step(crc, d[(BYTES-1-i)*8 +: 8]);
		end
	end

endmodule

//--- hdl/crc32_tail_comb.sv
module crc32_tail_comb (
	input  logic [31:0]                   d,
	input  logic [2:0]                    len,
	input  logic [crc_pkg::crc_width-1:0] c,
	output logic [crc_pkg::crc_width-1:0] crc
);
	import crc_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Fold the leading len bytes of one word

	// Byte 0 sits in d[31:24]
	// A zero length passes the state through untouched
	// Lengths above four fold the whole word
	always_comb begin
		crc = c;
		for (int i = 0; i < 4; i++) begin
			// Bytes past the count are skipped
			if (len > 3'(i)) begin
				crc = crc32_byte_step(crc, d[31-8*i -: 8]);
			end
		end
	end

endmodule

//--- hdl/crc32_x128_pipe.sv
module crc32_x128_pipe (
	input  logic                 clk,
	input  logic                 reset,
	input  crc_pkg::crc_block_t  blk,
	output crc_pkg::crc_result_t result
);
	import crc_pkg::*;

	// State of a last block as it moves down the finishing stages
	typedef struct packed {
		logic                     done;
		logic [len_width-2:0]     len;
		logic [block_bytes*8-1:0] data;
		logic [crc_width-1:0]     crc;
	} stage_t;

	// Running state between blocks of one frame
	logic [crc_width-1:0] crc_run;
	logic [crc_width-1:0] crc_seed;

	// Combinational results
	logic [crc_width-1:0] crc_x128;
	logic [crc_width-1:0] crc_x64;
	logic [crc_width-1:0] crc_x32;
	logic [crc_width-1:0] crc_tail;

	stage_t               s0;
	stage_t               s1;
	stage_t               s2;
	logic [crc_width-1:0] s3_crc;

	// One valid bit per stage
	logic [3:0] vld;

	////////////////////////////////////////////////////////////////////////////
	// Full block fold

	// A start block ignores whatever the last frame left behind
	assign crc_seed = blk.start ? crc_init : crc_run;

	crc32_block_comb #(
		.BYTES(block_bytes)
	) u_x128 (
		.d  (blk.data),
		.c  (crc_seed),
		.crc(crc_x128)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			crc_run <= crc_init;
		end else if (blk.update) begin
			crc_run <= crc_x128;
		end
	end

	// Stage 0 takes the pre-block state
	// A full 16 byte last block is already finished here
	always_ff @(posedge clk) begin
		s0.data <= blk.data;
		if (blk.len[len_width-1]) begin
			s0.done <= 1'b1;
			s0.len  <= '0;
			s0.crc  <= crc_x128;
		end else begin
			s0.done <= 1'b0;
			s0.len  <= blk.len[len_width-2:0];
			s0.crc  <= crc_seed;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Partial block finishing

	// Eight byte step on the front of the block
	crc32_block_comb #(
		.BYTES(8)
	) u_x64 (
		.d  (s0.data[block_bytes*8-1 -: 64]),
		.c  (s0.crc),
		.crc(crc_x64)
	);

	always_ff @(posedge clk) begin
		if (!s0.done && s0.len[3]) begin
			s1.done <= (s0.len[2:0] == 3'd0);
			s1.len  <= {1'b0, s0.len[2:0]};
			s1.data <= s0.data << 64;
			s1.crc  <= crc_x64;
		end else begin
			s1 <= s0;
		end
	end

	// Four byte step, only taken with at least four bytes left
	crc32_tail_comb u_x32 (
		.d  (s1.data[block_bytes*8-1 -: 32]),
		.len({s1.len[2], 2'b00}),
		.c  (s1.crc),
		.crc(crc_x32)
	);

	always_ff @(posedge clk) begin
		if (!s1.done && s1.len[2]) begin
			s2.done <= (s1.len[1:0] == 2'd0);
			s2.len  <= {2'b00, s1.len[1:0]};
			s2.data <= s1.data << 32;
			s2.crc  <= crc_x32;
		end else begin
			s2 <= s1;
		end
	end

	// Last zero to three bytes
	crc32_tail_comb u_tail (
		.d  (s2.data[block_bytes*8-1 -: 32]),
		.len({1'b0, s2.len[1:0]}),
		.c  (s2.crc),
		.crc(crc_tail)
	);

	always_ff @(posedge clk) begin
		s3_crc <= s2.done ? s2.crc : crc_tail;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output and valid tracking

	always_ff @(posedge clk) begin
		if (reset) begin
			vld <= '0;
		end else begin
			vld <= {vld[2:0], blk.update && blk.last};
		end
	end

	// Final complement gives the value as sent on the wire
	always_ff @(posedge clk) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= vld[3];
		end
		result.crc <= ~s3_crc;
	end

	// The register block only issues legal final lengths
	a_last_len: assert property (@(posedge clk) disable iff (reset)
		blk.update && blk.last |-> (blk.len >= len_width'(1)) &&
			(blk.len <= len_width'(block_bytes)));

	// Command issue stays quiet while reset is held
	a_no_update_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !blk.update);

endmodule

//--- hdl/crc_regs.sv
module crc_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  wb_pkg::wb_req_t      wb_req,
	output wb_pkg::wb_rsp_t      wb_rsp,
	output crc_pkg::crc_block_t  blk,
	input  crc_pkg::crc_result_t result
);
	import wb_pkg::*;

	// Stored data lanes, lane 0 first on the wire
	logic [3:0][wb_dat_width-1:0] lanes;

	// Last command word, kept for readback
	logic [wb_dat_width-1:0] cmd_word;
	logic [wb_dat_width-1:0] result_reg;
	logic [wb_dat_width-1:0] rd_data;
	logic                    done;
	logic                    busy;

	// Request sampled this cycle
	logic     access;
	logic     cmd_wr;
	wb_word_u wr_word;

	////////////////////////////////////////////////////////////////////////////
	// Bus handshake

	// No request is taken in the ack cycle
	assign access  = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
	assign wr_word.raw = wb_req.dat;
	assign cmd_wr  = access && wb_req.we && (wb_req.adr == reg_cmd);

	always_comb begin
		case (wb_req.adr)
			reg_lane0:  rd_data = lanes[0];
			reg_lane1:  rd_data = lanes[1];
			reg_lane2:  rd_data = lanes[2];
			reg_lane3:  rd_data = lanes[3];
			reg_cmd:    rd_data = cmd_word;
			reg_result: rd_data = result_reg;
			reg_status: rd_data = {{(wb_dat_width-2){1'b0}}, busy, done};
			default:    rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_rsp.ack <= 1'b0;
		end else begin
			wb_rsp.ack <= access;
		end
		// Read data is held with the ack
		if (access && !wb_req.we) begin
			wb_rsp.dat <= rd_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Lane and command writes

	always_ff @(posedge clk) begin
		if (access && wb_req.we) begin
			case (wb_req.adr)
				reg_lane0: lanes[0] <= wb_req.dat;
				reg_lane1: lanes[1] <= wb_req.dat;
				reg_lane2: lanes[2] <= wb_req.dat;
				reg_lane3: lanes[3] <= wb_req.dat;
				reg_cmd:   cmd_word <= wb_req.dat;
				default: ;
			endcase
		end
	end

	// Update lasts one cycle after the command edge
	always_ff @(posedge clk) begin
		if (reset) begin
			blk.update <= 1'b0;
		end else begin
			blk.update <= cmd_wr;
		end
		if (cmd_wr) begin
			blk.start <= wr_word.cmd.start;
			blk.last  <= wr_word.cmd.last;
			blk.len   <= wr_word.cmd.len;
			blk.data  <= {lanes[0], lanes[1], lanes[2], lanes[3]};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Result capture and status

	// A new frame wins over a result landing in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			done       <= 1'b0;
			busy       <= 1'b0;
			result_reg <= '0;
		end else begin
			if (result.valid) begin
				result_reg <= result.crc;
				busy       <= 1'b0;
				done       <= 1'b1;
			end
			if (cmd_wr && wr_word.cmd.last) begin
				busy <= 1'b1;
			end
			if (cmd_wr && wr_word.cmd.start) begin
				done <= 1'b0;
			end
		end
	end

	// Single cycle ack per transfer
	a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack);

	// Every pipeline result belongs to a frame that was closed with last
	a_result_when_busy: assert property (@(posedge clk) disable iff (reset)
		result.valid |-> busy);

endmodule

//--- hdl/crc_offload_top.sv
module crc_offload_top (
	input  logic            clk,
	input  logic            reset,
	input  wb_pkg::wb_req_t wb_req,
	output wb_pkg::wb_rsp_t wb_rsp
);
	import crc_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Register block to pipeline

	// Block issued by a command write
	crc_block_t  blk;

	// Finished CRC coming back
	crc_result_t result;

	// Host side registers and command issue
	crc_regs u_regs (
		.clk   (clk),
		.reset (reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.blk   (blk),
		.result(result)
	);

	// 128 bit CRC datapath
	crc32_x128_pipe u_pipe (
		.clk   (clk),
		.reset (reset),
		.blk   (blk),
		.result(result)
	);

endmodule

//--- verification/crc_offload_tb.sv
module crc_offload_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import crc_pkg::*;
	import wb_pkg::*;

	// Cycles allowed for one ack, and status polls allowed per frame
	localparam int ack_timeout  = 8;
	localparam int done_timeout = 32;

	// Frame fill patterns
	localparam logic [1:0] pat_fixed  = 2'd0;
	localparam logic [1:0] pat_random = 2'd1;
	localparam logic [1:0] pat_text   = 2'd2;

	// One table row, a known CRC overrides the reference model
	typedef struct packed {
		logic [6:0]  len;
		logic [1:0]  pat;
		logic        has_exp;
		logic [31:0] exp_crc;
	} frame_t;

	logic       clk;
	logic       reset;
	wb_req_t    wb_req;
	wb_rsp_t    wb_rsp;

	// Frame bytes, byte 0 first on the wire
	logic [7:0]  frame_bytes [0:63];
	frame_t      frames [0:21];
	logic [31:0] prev_crc;
	integer      seed;

	crc_offload_top dut (
		.clk   (clk),
		.reset (reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare tasks

	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			$display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_rsp(input wb_rsp_t got, input logic exp_ack, input string name);
		if (got.ack !== exp_ack) begin
			$display("error at %0t ns: %s.ack is %b, expected %b", $time, name, got.ack, exp_ack);
			stop_on_error();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone master

	// Called on a falling edge, returns on a falling edge
	task automatic bus_cycle(input logic we, input logic [wb_adr_width-1:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		waited = 0;
		@(negedge clk);
		while (wb_rsp.ack !== 1'b1) begin
			if (waited == ack_timeout) begin
				$display("timeout: no Wishbone ack for the access to address %0d", adr);
				stop_on_error();
			end
			waited++;
			@(negedge clk);
		end
		// Read data is valid with the ack
		rdat = wb_rsp.dat;
		wb_req = '0;
		// Ack lasts exactly one cycle
		@(negedge clk);
		check_rsp(wb_rsp, 1'b0, "wb_rsp");
	endtask

	task automatic wb_write(input logic [wb_adr_width-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [wb_adr_width-1:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'h0, dat);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and frame handling

	// Bitwise Ethernet CRC, 0x04C11DB7 reflected, LSB of each byte first
	function automatic logic [31:0] ref_crc(input int n);
		logic [31:0] c;
		logic        fb;
		c = 32'hFFFFFFFF;
		for (int i = 0; i < n; i++) begin
			for (int k = 0; k < 8; k++) begin
				fb = c[0] ^ frame_bytes[i][k];
				c  = c >> 1;
				if (fb) begin
					c = c ^ 32'hEDB88320;
				end
			end
		end
		return ~c;
	endfunction

	task automatic fill_frame(input logic [1:0] pat);
		string text;
		text = "123456789";
		for (int i = 0; i < 64; i++) begin
			case (pat)
				pat_text:   frame_bytes[i] = (i < text.len()) ? text[i] : 8'h00;
				pat_random: frame_bytes[i] = 8'($random(seed));
				default:    frame_bytes[i] = 8'(i * 29 + 7);
			endcase
		end
	endtask

	// Lanes then a command per 16 byte beat, then poll status
	task automatic run_frame(input int n, output logic [31:0] crc);
		int          beats;
		int          base;
		int          polls;
		logic [31:0] rd;
		crc_cmd_t    cmd;
		beats = (n + 15) / 16;
		for (int b = 0; b < beats; b++) begin
			base = b * 16;
			for (int l = 0; l < 4; l++) begin
				wb_write(reg_lane0 + 3'(l), {frame_bytes[base+4*l], frame_bytes[base+4*l+1],
					frame_bytes[base+4*l+2], frame_bytes[base+4*l+3]});
			end
			cmd       = '0;
			cmd.start = (b == 0);
			cmd.last  = (b == beats - 1);
			cmd.len   = cmd.last ? len_width'(n - base) : len_width'(block_bytes);
			wb_write(reg_cmd, cmd);
			if (b == 0) begin
				// Start clears done, the old result stays readable
				wb_read(reg_status, rd);
				check_word(rd, {30'b0, cmd.last, 1'b0}, "reg_status after start");
				wb_read(reg_result, rd);
				check_word(rd, prev_crc, "reg_result before done");
			end
		end
		polls = 0;
		wb_read(reg_status, rd);
		while (rd[0] !== 1'b1) begin
			check_word(rd, 32'h2, "reg_status while busy");
			if (polls == done_timeout) begin
				$display("timeout: done never set for a frame of %0d bytes", n);
				stop_on_error();
			end
			polls++;
			wb_read(reg_status, rd);
		end
		check_word(rd, 32'h1, "reg_status after done");
		// Command register keeps the word of the final beat
		wb_read(reg_cmd, rd);
		check_word(rd, cmd, "reg_cmd");
		wb_read(reg_result, crc);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [31:0] exp;
		logic [31:0] lane_val [0:3];
		seed     = 11355;
		reset    = 1'b1;
		wb_req   = '0;
		prev_crc = '0;
		// Check string first, then every single block length, then multi block
		frames = '{
			'{7'd9, pat_text, 1'b1, 32'hCBF43926},
			'{7'd1, pat_fixed, 1'b0, 32'h0}, '{7'd2, pat_random, 1'b0, 32'h0},
			'{7'd3, pat_fixed, 1'b0, 32'h0}, '{7'd4, pat_random, 1'b0, 32'h0},
			'{7'd5, pat_fixed, 1'b0, 32'h0}, '{7'd6, pat_random, 1'b0, 32'h0},
			'{7'd7, pat_fixed, 1'b0, 32'h0}, '{7'd8, pat_random, 1'b0, 32'h0},
			'{7'd9, pat_fixed, 1'b0, 32'h0}, '{7'd10, pat_random, 1'b0, 32'h0},
			'{7'd11, pat_fixed, 1'b0, 32'h0}, '{7'd12, pat_random, 1'b0, 32'h0},
			'{7'd13, pat_fixed, 1'b0, 32'h0}, '{7'd14, pat_random, 1'b0, 32'h0},
			'{7'd15, pat_fixed, 1'b0, 32'h0}, '{7'd16, pat_random, 1'b0, 32'h0},
			'{7'd17, pat_fixed, 1'b0, 32'h0}, '{7'd28, pat_random, 1'b0, 32'h0},
			'{7'd32, pat_fixed, 1'b0, 32'h0}, '{7'd45, pat_random, 1'b0, 32'h0},
			'{7'd64, pat_random, 1'b0, 32'h0}
		};
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Idle state after reset
		wb_read(reg_status, rd);
		check_word(rd, 32'h0, "reg_status after reset");
		wb_read(reg_result, rd);
		check_word(rd, 32'h0, "reg_result after reset");

		// Lane readback
		for (int l = 0; l < 4; l++) begin
			lane_val[l] = $random(seed);
			wb_write(reg_lane0 + 3'(l), lane_val[l]);
		end
		for (int l = 0; l < 4; l++) begin
			wb_read(reg_lane0 + 3'(l), rd);
			check_word(rd, lane_val[l], $sformatf("reg_lane%0d", l));
		end

		// Frames back to back, each result independent of the one before
		for (int f = 0; f < 22; f++) begin
			fill_frame(frames[f].pat);
			exp = ref_crc(frames[f].len);
			if (frames[f].has_exp) begin
				check_word(exp, frames[f].exp_crc, "reference model CRC");
			end
			run_frame(frames[f].len, rd);
			check_word(rd, exp, $sformatf("reg_result of frame %0d, %0d bytes", f, frames[f].len));
			prev_crc = exp;
		end

		$display("Verification passed");
		$finish;
	end

endmodule

//--- verilog.f
hdl/crc_pkg.sv
hdl/wb_pkg.sv
hdl/crc32_block_comb.sv
hdl/crc32_tail_comb.sv
hdl/crc32_x128_pipe.sv
hdl/crc_regs.sv
hdl/crc_offload_top.sv
verification/crc_offload_tb.sv

//--- Bender.yml
package:
  name: crc_offload

sources:
  # Packages first, then the datapath, then the top level
  - hdl/crc_pkg.sv
  - hdl/wb_pkg.sv
  - hdl/crc32_block_comb.sv
  - hdl/crc32_tail_comb.sv
  - hdl/crc32_x128_pipe.sv
  - hdl/crc_regs.sv
  - hdl/crc_offload_top.sv

  - target: test
    files:
      - verification/crc_offload_tb.sv
